// File: verilog/sv32_pkg.sv
package sv32_pkg;

   //////////////////////////////
   // field widths
   //////////////////////////////

   localparam int PAGE_OFFSET_W = 12;
   localparam int VPN_W         = 10;
   localparam int PPN_W         = 22;
   localparam int PTE_BYTES     = 4;

   //////////////////////////////
   // architectural formats
   //////////////////////////////

   // mode 0 is bare, 1 is sv32
   typedef struct packed {
      logic             mode;
      logic [8:0]       asid;
      logic [PPN_W-1:0] ppn;
   } satp_t;

   typedef struct packed {
      logic [VPN_W-1:0]         vpn1;
      logic [VPN_W-1:0]         vpn0;
      logic [PAGE_OFFSET_W-1:0] offset;
   } vaddr_t;

   // ppn1 is the upper part of the 22 bit ppn
   typedef struct packed {
      logic [PPN_W-VPN_W-1:0] ppn1;
      logic [VPN_W-1:0]       ppn0;
      logic [1:0]             rsw;
      logic                   d;
      logic                   a;
      logic                   g;
      logic                   u;
      logic                   x;
      logic                   w;
      logic                   r;
      logic                   v;
   } pte_t;

endpackage

// File: verilog/mmu_pkg.sv
package mmu_pkg;

   localparam int TLB_ENTRIES = 16;
   localparam int TLB_IDX_W   = 4;

   //////////////////////////////
   // enums
   //////////////////////////////

   typedef enum logic [1:0] {
      PRIV_U = 2'd0,
      PRIV_S = 2'd1,
      PRIV_M = 2'd3
   } priv_e;

   typedef enum logic [1:0] {
      ACC_FETCH = 2'd0,
      ACC_LOAD  = 2'd1,
      ACC_STORE = 2'd2
   } access_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PTE1,
      ST_PTE0,
      ST_ACCESS,
      ST_DONE
   } walk_state_e;

   // page fault causes
   localparam logic [4:0] EXC_INST_PF  = 5'd12;
   localparam logic [4:0] EXC_LOAD_PF  = 5'd13;
   localparam logic [4:0] EXC_STORE_PF = 5'd15;

   //////////////////////////////
   // transactions
   //////////////////////////////

   typedef struct packed {
      logic        valid;
      logic [31:0] addr;
   } fetch_req_t;

   typedef struct packed {
      logic        valid;
      logic        write;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } lsu_req_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] data;
      logic        fault;
      logic [4:0]  cause;
      logic [31:0] tval;
   } mmu_resp_t;

   typedef struct packed {
      logic        valid;
      logic        write;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } bus_req_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] data;
   } bus_resp_t;

   typedef struct packed {
      logic        valid;
      logic [19:0] vpn;
      logic [19:0] ppn;
   } tlb_entry_t;

endpackage

// File: verilog/mmu_tlb.sv
`timescale 1ns/1ns

module mmu_tlb (
   input  logic        clk,
   input  logic        rstn,
   input  logic [19:0] lookup_vpn,
   input  logic        fill,
   input  logic [19:0] fill_vpn,
   input  logic [19:0] fill_ppn,
   input  logic        flush,
   output logic        hit,
   output logic [19:0] hit_ppn
);

   mmu_pkg::tlb_entry_t entries [mmu_pkg::TLB_ENTRIES];

   logic [mmu_pkg::TLB_IDX_W-1:0] victim;
   logic [mmu_pkg::TLB_IDX_W-1:0] free_idx;
   logic                          free_found;
   logic                          fill_present;

   //////////////////////////////
   // lookup
   //////////////////////////////

   // tags are unique, so or-ing the matches is safe
   always_comb begin
      hit     = 1'b0;
      hit_ppn = '0;
      for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
         if (entries[i].valid && entries[i].vpn == lookup_vpn) begin
            hit     = 1'b1;
            hit_ppn = hit_ppn | entries[i].ppn;
         end
      end
   end

   //////////////////////////////
   // fill slot selection
   //////////////////////////////

   // scan downwards so the lowest free slot wins
   always_comb begin
      fill_present = 1'b0;
      free_found   = 1'b0;
      free_idx     = '0;
      for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
         if (entries[i].valid && entries[i].vpn == fill_vpn) begin
            fill_present = 1'b1;
         end
         if (!entries[i].valid) begin
            free_found = 1'b1;
            free_idx   = mmu_pkg::TLB_IDX_W'(i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         victim <= '0;
         for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            entries[i].valid <= 1'b0;
         end
      end else if (flush) begin
         for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            entries[i].valid <= 1'b0;
         end
      end else if (fill && !fill_present) begin
         if (free_found) begin
            entries[free_idx] <= '{valid: 1'b1, vpn: fill_vpn, ppn: fill_ppn};
         end else begin
            // full, replace round robin
            entries[victim] <= '{valid: 1'b1, vpn: fill_vpn, ppn: fill_ppn};
            victim          <= victim + 1'b1;
         end
      end
   end

endmodule

// File: verilog/pte_check.sv
`timescale 1ns/1ns

module pte_check (
   input  sv32_pkg::pte_t   pte,
   input  logic             level,
   input  mmu_pkg::access_e access,
   input  mmu_pkg::priv_e   priv,
   input  logic             sum,
   output logic             fault,
   output logic             leaf
);

   logic bad_encoding;
   logic bad_misaligned;
   logic bad_priv;
   logic access_ok;
   logic bad_ad;

   assign leaf = pte.r | pte.x;

   // reserved w without r, or not valid at all
   assign bad_encoding = !pte.v || (pte.w && !pte.r);

   // superpage must be aligned to 4 MiB
   assign bad_misaligned = level && (pte.ppn0 != '0);

   //////////////////////////////
   // leaf permission checks
   //////////////////////////////

   assign bad_priv = (pte.u && priv == mmu_pkg::PRIV_S && !sum) ||
                     (!pte.u && priv == mmu_pkg::PRIV_U);

   always_comb begin
      case (access)
         mmu_pkg::ACC_FETCH: access_ok = pte.x;
         mmu_pkg::ACC_LOAD:  access_ok = pte.r;
         mmu_pkg::ACC_STORE: access_ok = pte.w;
         default:            access_ok = 1'b0;
      endcase
   end

   // no hardware a/d update, missing bits fault
   assign bad_ad = !pte.a || (access == mmu_pkg::ACC_STORE && !pte.d);

   always_comb begin
      if (bad_encoding) begin
         fault = 1'b1;
      end else if (leaf) begin
         fault = bad_misaligned || bad_priv || !access_ok || bad_ad;
      end else begin
         // pointer at the last level
         fault = !level;
      end
   end

endmodule

// File: verilog/sv32_walker.sv
`timescale 1ns/1ns

module sv32_walker (
   input  logic                clk,
   input  logic                rstn,
   input  sv32_pkg::satp_t     satp,
   input  mmu_pkg::priv_e      priv,
   input  logic                sum,
   input  logic                flush_tlb,
   input  mmu_pkg::fetch_req_t fetch_req,
   input  mmu_pkg::lsu_req_t   lsu_req,
   input  mmu_pkg::bus_resp_t  bus_resp,
   input  logic                tlb_hit,
   input  logic [19:0]         tlb_ppn,
   input  logic                pte_fault,
   input  logic                pte_leaf,
   output mmu_pkg::mmu_resp_t  fetch_resp,
   output mmu_pkg::mmu_resp_t  lsu_resp,
   output mmu_pkg::bus_req_t   bus_req,
   output logic [19:0]         tlb_vpn,
   output logic                tlb_fill,
   output logic [19:0]         tlb_fill_vpn,
   output logic [19:0]         tlb_fill_ppn,
   output logic                tlb_flush,
   output sv32_pkg::pte_t      pte,
   output logic                level,
   output mmu_pkg::access_e    access
);

   mmu_pkg::walk_state_e state;
   mmu_pkg::walk_state_e state_n;

   // captured request
   mmu_pkg::access_e acc_q;
   sv32_pkg::vaddr_t va_q;
   logic [31:0]      wdata_q;
   logic [3:0]       wstrb_q;

   logic              accept;
   logic              bypass;
   mmu_pkg::lsu_req_t sel_req;
   sv32_pkg::vaddr_t  sel_va;
   mmu_pkg::access_e  sel_acc;
   logic              resp_to_fetch;
   logic [19:0]       leaf_ppn;
   logic [31:0]       pte1_addr;
   logic [31:0]       pte0_addr;
   logic [4:0]        fault_cause;
   logic              bus_fire;
   logic              resp_fire;
   mmu_pkg::bus_req_t  bus_n;
   mmu_pkg::mmu_resp_t resp_n;

   //////////////////////////////
   // arbitration
   //////////////////////////////

   assign accept = (state == mmu_pkg::ST_IDLE) && (fetch_req.valid || lsu_req.valid);
   assign bypass = !satp.mode || priv == mmu_pkg::PRIV_M;

   // fetch wins, lsu keeps waiting
   always_comb begin
      if (fetch_req.valid) begin
         sel_req = '{valid: 1'b1, write: 1'b0, addr: fetch_req.addr, wdata: '0, wstrb: '0};
         sel_acc = mmu_pkg::ACC_FETCH;
      end else begin
         sel_req = lsu_req;
         sel_acc = lsu_req.write ? mmu_pkg::ACC_STORE : mmu_pkg::ACC_LOAD;
      end
   end

   assign sel_va        = sel_req.addr;
   assign resp_to_fetch = (state == mmu_pkg::ST_IDLE) ? fetch_req.valid
                                                      : (acc_q == mmu_pkg::ACC_FETCH);

   assign tlb_vpn   = {sel_va.vpn1, sel_va.vpn0};
   assign tlb_flush = accept && flush_tlb;

   //////////////////////////////
   // walk datapath
   //////////////////////////////

   assign pte    = bus_resp.data;
   assign level  = (state == mmu_pkg::ST_PTE1);
   assign access = acc_q;

   assign pte1_addr = {satp.ppn[19:0], 12'b0} +
                      32'(sel_va.vpn1) * 32'(sv32_pkg::PTE_BYTES);
   assign pte0_addr = {pte.ppn1[9:0], pte.ppn0, 12'b0} +
                      32'(va_q.vpn0) * 32'(sv32_pkg::PTE_BYTES);

   // superpage keeps the virtual vpn0
   assign leaf_ppn = level ? {pte.ppn1[9:0], va_q.vpn0} : {pte.ppn1[9:0], pte.ppn0};

   // tlb has no u bit, so pages reached only through sum are not cached
   assign tlb_fill = bus_resp.valid && pte_leaf && !pte_fault &&
                     (state == mmu_pkg::ST_PTE1 || state == mmu_pkg::ST_PTE0) &&
                     !(pte.u && priv == mmu_pkg::PRIV_S && sum);
   assign tlb_fill_vpn = {va_q.vpn1, va_q.vpn0};
   assign tlb_fill_ppn = leaf_ppn;

   always_comb begin
      case (acc_q)
         mmu_pkg::ACC_FETCH: fault_cause = mmu_pkg::EXC_INST_PF;
         mmu_pkg::ACC_LOAD:  fault_cause = mmu_pkg::EXC_LOAD_PF;
         default:            fault_cause = mmu_pkg::EXC_STORE_PF;
      endcase
   end

   //////////////////////////////
   // next state
   //////////////////////////////

   always_comb begin
      state_n   = state;
      bus_fire  = 1'b0;
      bus_n     = '0;
      resp_fire = 1'b0;
      resp_n    = '0;
      case (state)
         mmu_pkg::ST_IDLE: begin
            if (accept) begin
               if (flush_tlb) begin
                  resp_fire    = 1'b1;
                  resp_n.valid = 1'b1;
                  state_n      = mmu_pkg::ST_DONE;
               end else begin
                  bus_fire = 1'b1;
                  bus_n    = mmu_pkg::bus_req_t'(sel_req);
                  if (bypass) begin
                     state_n = mmu_pkg::ST_ACCESS;
                  end else if (tlb_hit) begin
                     bus_n.addr = {tlb_ppn, sel_va.offset};
                     state_n    = mmu_pkg::ST_ACCESS;
                  end else begin
                     bus_n   = '{valid: 1'b1, write: 1'b0, addr: pte1_addr, wdata: '0, wstrb: '0};
                     state_n = mmu_pkg::ST_PTE1;
                  end
               end
            end
         end
         mmu_pkg::ST_PTE1, mmu_pkg::ST_PTE0: begin
            if (bus_resp.valid) begin
               if (pte_fault) begin
                  resp_fire = 1'b1;
                  resp_n    = '{valid: 1'b1, data: '0, fault: 1'b1,
                                cause: fault_cause, tval: va_q};
                  state_n   = mmu_pkg::ST_DONE;
               end else if (pte_leaf) begin
                  bus_fire = 1'b1;
                  bus_n    = '{valid: 1'b1, write: (acc_q == mmu_pkg::ACC_STORE),
                               addr: {leaf_ppn, va_q.offset}, wdata: wdata_q, wstrb: wstrb_q};
                  state_n  = mmu_pkg::ST_ACCESS;
               end else begin
                  // only reached at level 1, a level 0 pointer faults
                  bus_fire = 1'b1;
                  bus_n    = '{valid: 1'b1, write: 1'b0, addr: pte0_addr, wdata: '0, wstrb: '0};
                  state_n  = mmu_pkg::ST_PTE0;
               end
            end
         end
         mmu_pkg::ST_ACCESS: begin
            if (bus_resp.valid) begin
               resp_fire    = 1'b1;
               resp_n.valid = 1'b1;
               resp_n.data  = bus_resp.data;
               state_n      = mmu_pkg::ST_DONE;
            end
         end
         default: state_n = mmu_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         state            <= mmu_pkg::ST_IDLE;
         bus_req.valid    <= 1'b0;
         fetch_resp.valid <= 1'b0;
         lsu_resp.valid   <= 1'b0;
      end else begin
         state <= state_n;
         if (bus_fire) begin
            bus_req <= bus_n;
         end else begin
            bus_req.valid <= 1'b0;
         end
         if (resp_fire && resp_to_fetch) begin
            fetch_resp <= resp_n;
         end else begin
            fetch_resp.valid <= 1'b0;
         end
         if (resp_fire && !resp_to_fetch) begin
            lsu_resp <= resp_n;
         end else begin
            lsu_resp.valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         acc_q   <= sel_acc;
         va_q    <= sel_va;
         wdata_q <= sel_req.wdata;
         wstrb_q <= sel_req.wstrb;
      end
   end

endmodule

// File: verilog/sv32_mmu.sv
`timescale 1ns/1ns

module sv32_mmu (
   input  logic                clk,
   input  logic                rstn,
   input  sv32_pkg::satp_t     satp,
   input  mmu_pkg::priv_e      priv,
   input  logic                sum,
   input  logic                flush_tlb,
   input  mmu_pkg::fetch_req_t fetch_req,
   input  mmu_pkg::lsu_req_t   lsu_req,
   input  mmu_pkg::bus_resp_t  bus_resp,
   output mmu_pkg::mmu_resp_t  fetch_resp,
   output mmu_pkg::mmu_resp_t  lsu_resp,
   output mmu_pkg::bus_req_t   bus_req
);

   logic             tlb_hit;
   logic [19:0]      tlb_ppn;
   logic [19:0]      tlb_vpn;
   logic             tlb_fill;
   logic [19:0]      tlb_fill_vpn;
   logic [19:0]      tlb_fill_ppn;
   logic             tlb_flush;
   logic             pte_fault;
   logic             pte_leaf;
   sv32_pkg::pte_t   pte;
   logic             level;
   mmu_pkg::access_e access;

   sv32_walker walker_i (
      .clk          (clk),
      .rstn         (rstn),
      .satp         (satp),
      .priv         (priv),
      .sum          (sum),
      .flush_tlb    (flush_tlb),
      .fetch_req    (fetch_req),
      .lsu_req      (lsu_req),
      .bus_resp     (bus_resp),
      .tlb_hit      (tlb_hit),
      .tlb_ppn      (tlb_ppn),
      .pte_fault    (pte_fault),
      .pte_leaf     (pte_leaf),
      .fetch_resp   (fetch_resp),
      .lsu_resp     (lsu_resp),
      .bus_req      (bus_req),
      .tlb_vpn      (tlb_vpn),
      .tlb_fill     (tlb_fill),
      .tlb_fill_vpn (tlb_fill_vpn),
      .tlb_fill_ppn (tlb_fill_ppn),
      .tlb_flush    (tlb_flush),
      .pte          (pte),
      .level        (level),
      .access       (access)
   );

   mmu_tlb tlb_i (
      .clk        (clk),
      .rstn       (rstn),
      .lookup_vpn (tlb_vpn),
      .fill       (tlb_fill),
      .fill_vpn   (tlb_fill_vpn),
      .fill_ppn   (tlb_fill_ppn),
      .flush      (tlb_flush),
      .hit        (tlb_hit),
      .hit_ppn    (tlb_ppn)
   );

   // priv and sum come straight from the cpu
   pte_check check_i (
      .pte    (pte),
      .level  (level),
      .access (access),
      .priv   (priv),
      .sum    (sum),
      .fault  (pte_fault),
      .leaf   (pte_leaf)
   );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // reset is active high, held for two edges
   initial begin
      rstn = 1'b1;
      repeat (2) @(posedge clk);
      rstn <= 1'b0;
   end

endmodule

// File: test/sv32_mmu_sva.sv
`timescale 1ns/1ns

module sv32_mmu_sva (
   input logic               clk,
   input logic               rstn,
   input mmu_pkg::bus_req_t  bus_req,
   input mmu_pkg::mmu_resp_t fetch_resp,
   input mmu_pkg::mmu_resp_t lsu_resp
);

   int failures = 0;

   function automatic logic known_cause(input logic [4:0] cause);
      return cause == mmu_pkg::EXC_INST_PF || cause == mmu_pkg::EXC_LOAD_PF ||
             cause == mmu_pkg::EXC_STORE_PF;
   endfunction

   bus_pulse: assert property (@(posedge clk) disable iff (rstn)
      bus_req.valid |=> !bus_req.valid)
      else begin
         $error("bus request valid held for two cycles");
         failures++;
      end

   one_resp: assert property (@(posedge clk) disable iff (rstn)
      !(fetch_resp.valid && lsu_resp.valid))
      else begin
         $error("fetch and load/store responses valid together");
         failures++;
      end

   // a response and a bus request never share a cycle
   no_bus_on_resp: assert property (@(posedge clk) disable iff (rstn)
      (fetch_resp.valid || lsu_resp.valid) |-> !bus_req.valid)
      else begin
         $error("bus request issued while a response is valid");
         failures++;
      end

   fault_cause: assert property (@(posedge clk) disable iff (rstn)
      ((fetch_resp.valid && fetch_resp.fault) || (lsu_resp.valid && lsu_resp.fault)) |->
      known_cause(fetch_resp.valid ? fetch_resp.cause : lsu_resp.cause))
      else begin
         $error("fault response with an unknown cause code");
         failures++;
      end

endmodule

bind sv32_mmu sv32_mmu_sva sva_i (
   .clk        (clk),
   .rstn       (rstn),
   .bus_req    (bus_req),
   .fetch_resp (fetch_resp),
   .lsu_resp   (lsu_resp)
);

// File: test/sv32_mmu_tb.sv
`timescale 1ns/1ns

module sv32_mmu_tb;

   localparam int          NUM_TESTS    = 6;
   localparam int          RESP_TIMEOUT = 200;
   localparam logic [21:0] ROOT_PPN     = 22'h00010;
   localparam logic [21:0] L0_BASE      = 22'h00100;

   // pte flag bits
   localparam logic [7:0] F_V = 8'h01;
   localparam logic [7:0] F_R = 8'h02;
   localparam logic [7:0] F_W = 8'h04;
   localparam logic [7:0] F_X = 8'h08;
   localparam logic [7:0] F_U = 8'h10;
   localparam logic [7:0] F_A = 8'h40;
   localparam logic [7:0] F_D = 8'h80;

   logic                clk;
   logic                rstn;
   sv32_pkg::satp_t     satp;
   mmu_pkg::priv_e      priv;
   logic                sum;
   logic                flush_tlb;
   mmu_pkg::fetch_req_t fetch_req;
   mmu_pkg::lsu_req_t   lsu_req;
   mmu_pkg::bus_resp_t  bus_resp;
   mmu_pkg::mmu_resp_t  fetch_resp;
   mmu_pkg::mmu_resp_t  lsu_resp;
   mmu_pkg::bus_req_t   bus_req;

   int errors       = 0;
   int tests_run    = 0;
   int tests_failed = 0;

   tb_clock clock_i (
      .clk  (clk),
      .rstn (rstn)
   );

   sv32_mmu dut_i (
      .clk        (clk),
      .rstn       (rstn),
      .satp       (satp),
      .priv       (priv),
      .sum        (sum),
      .flush_tlb  (flush_tlb),
      .fetch_req  (fetch_req),
      .lsu_req    (lsu_req),
      .bus_resp   (bus_resp),
      .fetch_resp (fetch_resp),
      .lsu_resp   (lsu_resp),
      .bus_req    (bus_req)
   );

   //////////////////////////////
   // memory model
   //////////////////////////////

   logic [31:0]       mem [logic [31:0]];
   logic [31:0]       bus_log [$];
   mmu_pkg::bus_req_t last_req;
   integer            seed = 38;
   logic              mem_busy;
   int                mem_wait;
   logic [31:0]       mem_data;
   logic [31:0]       mem_word;

   // unwritten words read back a pattern of their address
   function automatic logic [31:0] mem_read(input logic [31:0] addr);
      logic [31:0] key;
      key = {addr[31:2], 2'b00};
      return mem.exists(key) ? mem[key] : (key ^ 32'h5a5a_c3c3);
   endfunction

   task automatic mem_write(input logic [31:0] addr, input logic [31:0] data);
      mem[{addr[31:2], 2'b00}] = data;
   endtask

   always @(posedge clk) begin
      bus_resp.valid <= 1'b0;
      if (rstn) begin
         mem_busy <= 1'b0;
      end else if (mem_busy) begin
         if (mem_wait == 0) begin
            bus_resp <= '{valid: 1'b1, data: mem_data};
            mem_busy <= 1'b0;
         end else begin
            mem_wait <= mem_wait - 1;
         end
      end else if (bus_req.valid) begin
         bus_log.push_back(bus_req.addr);
         last_req = bus_req;
         mem_word = mem_read(bus_req.addr);
         if (bus_req.write) begin
            for (int b = 0; b < 4; b++) begin
               if (bus_req.wstrb[b]) begin
                  mem_word[8*b +: 8] = bus_req.wdata[8*b +: 8];
               end
            end
            mem_write(bus_req.addr, mem_word);
         end
         mem_data <= mem_word;
         // 1 to 4 edges of wait
         mem_wait <= $unsigned($random(seed)) % 4;
         mem_busy <= 1'b1;
      end
   end

   //////////////////////////////
   // page table helpers
   //////////////////////////////

   function automatic logic [31:0] pte_word(input logic [21:0] ppn, input logic [7:0] flags);
      return {ppn, 2'b00, flags};
   endfunction

   function automatic logic [31:0] l1_addr(input logic [31:0] va);
      return 32'(ROOT_PPN) * 4096 + 32'(va[31:22]) * 4;
   endfunction

   // one level 0 table per vpn1
   function automatic logic [31:0] l0_addr(input logic [31:0] va);
      return 32'(L0_BASE + 22'(va[31:22])) * 4096 + 32'(va[21:12]) * 4;
   endfunction

   task automatic map_4k(input logic [31:0] va, input logic [19:0] ppn, input logic [7:0] flags);
      mem_write(l1_addr(va), pte_word(L0_BASE + 22'(va[31:22]), F_V));
      mem_write(l0_addr(va), pte_word({2'b00, ppn}, flags));
   endtask

   //////////////////////////////
   // checks and requests
   //////////////////////////////

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_bus(input string name, input int count, input logic [31:0] a0,
                            input logic [31:0] a1, input logic [31:0] a2);
      logic [31:0] expected [3];
      expected = '{a0, a1, a2};
      check_equal({name, " bus count"}, 32'(count), 32'(bus_log.size()));
      for (int i = 0; i < count && i < bus_log.size(); i++) begin
         check_equal($sformatf("%s bus addr %0d", name, i), expected[i], bus_log[i]);
      end
   endtask

   task automatic expect_fault(input string name, input mmu_pkg::mmu_resp_t resp,
                               input logic [4:0] cause, input logic [31:0] va);
      check_equal({name, " fault"}, 32'd1, 32'(resp.fault));
      check_equal({name, " cause"}, 32'(cause), 32'(resp.cause));
      check_equal({name, " tval"}, va, resp.tval);
   endtask

   task automatic wait_resp(input logic fetch_side, output mmu_pkg::mmu_resp_t resp);
      int   cycles;
      logic done;
      cycles = 0;
      done   = 1'b0;
      resp   = '0;
      while (!done && cycles < RESP_TIMEOUT) begin
         @(posedge clk);
         cycles++;
         if (fetch_side && fetch_resp.valid) begin
            resp = fetch_resp;
            done = 1'b1;
         end else if (!fetch_side && lsu_resp.valid) begin
            resp = lsu_resp;
            done = 1'b1;
         end
      end
      assert (done) else begin
         $display("no response from the MMU within %0d cycles", RESP_TIMEOUT);
         errors++;
      end
   endtask

   task automatic lsu_access(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             input logic flush, output mmu_pkg::mmu_resp_t resp);
      bus_log.delete();
      @(posedge clk);
      lsu_req   <= '{valid: 1'b1, write: write, addr: addr, wdata: wdata, wstrb: wstrb};
      flush_tlb <= flush;
      wait_resp(1'b0, resp);
      lsu_req.valid <= 1'b0;
      flush_tlb     <= 1'b0;
   endtask

   task automatic fetch_access(input logic [31:0] addr, output mmu_pkg::mmu_resp_t resp);
      bus_log.delete();
      @(posedge clk);
      fetch_req <= '{valid: 1'b1, addr: addr};
      wait_resp(1'b1, resp);
      fetch_req.valid <= 1'b0;
   endtask

   task automatic report_test(input string name, input int start);
      tests_run++;
      if (errors != start) begin
         tests_failed++;
         $display("test %s: FAILED with %0d errors", name, errors - start);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   //////////////////////////////
   // tests
   //////////////////////////////

   task automatic bypass_paths();
      mmu_pkg::mmu_resp_t resp;
      int                 start;
      start = errors;
      satp <= '0;
      priv <= mmu_pkg::PRIV_S;
      lsu_access(1'b1, 32'h0000_4a10, 32'h1234_5678, 4'hf, 1'b0, resp);
      check_bus("bypass store", 1, 32'h0000_4a10, '0, '0);
      check_equal("bypass write", 32'd1, 32'(last_req.write));
      check_equal("bypass wdata", 32'h1234_5678, last_req.wdata);
      check_equal("bypass wstrb", 32'hf, 32'(last_req.wstrb));
      lsu_access(1'b0, 32'h0000_4a10, '0, '0, 1'b0, resp);
      check_equal("bypass load write", 32'd0, 32'(last_req.write));
      check_equal("bypass load data", 32'h1234_5678, resp.data);
      // translation on, but machine mode
      satp <= '{mode: 1'b1, asid: '0, ppn: ROOT_PPN};
      priv <= mmu_pkg::PRIV_M;
      mem_write(32'h8765_4320, 32'h0bad_f00d);
      lsu_access(1'b0, 32'h8765_4320, '0, '0, 1'b0, resp);
      check_bus("bypass mmode", 1, 32'h8765_4320, '0, '0);
      check_equal("bypass mmode data", 32'h0bad_f00d, resp.data);
      priv <= mmu_pkg::PRIV_S;
      report_test("bypass", start);
   endtask

   localparam logic [31:0] VA_WALK = {10'h005, 10'h023, 12'h3a4};

   task automatic two_level_walk();
      mmu_pkg::mmu_resp_t resp;
      int                 start;
      start = errors;
      map_4k(VA_WALK, 20'h00456, F_V | F_R | F_W | F_A | F_D);
      mem_write({20'h00456, 12'h3a4}, 32'hcafe_0001);
      lsu_access(1'b0, VA_WALK, '0, '0, 1'b0, resp);
      check_bus("walk", 3, l1_addr(VA_WALK), l0_addr(VA_WALK), {20'h00456, 12'h3a4});
      check_equal("walk write", 32'd0, 32'(last_req.write));
      check_equal("walk fault", 32'd0, 32'(resp.fault));
      check_equal("walk data", 32'hcafe_0001, resp.data);
      report_test("walk", start);
   endtask

   task automatic tlb_hit_and_flush();
      mmu_pkg::mmu_resp_t resp;
      int                 start;
      start = errors;
      mem_write({20'h00456, 12'h010}, 32'hcafe_0002);
      lsu_access(1'b0, {VA_WALK[31:12], 12'h010}, '0, '0, 1'b0, resp);
      check_bus("tlb hit", 1, {20'h00456, 12'h010}, '0, '0);
      check_equal("tlb hit data", 32'hcafe_0002, resp.data);
      lsu_access(1'b0, VA_WALK, '0, '0, 1'b1, resp);
      check_bus("tlb flush", 0, '0, '0, '0);
      check_equal("tlb flush data", 32'd0, resp.data);
      lsu_access(1'b0, VA_WALK, '0, '0, 1'b0, resp);
      check_bus("tlb rewalk", 3, l1_addr(VA_WALK), l0_addr(VA_WALK), {20'h00456, 12'h3a4});
      check_equal("tlb rewalk data", 32'hcafe_0001, resp.data);
      report_test("tlb", start);
   endtask

   task automatic superpage_mapping();
      mmu_pkg::mmu_resp_t resp;
      logic [31:0]        va;
      logic [31:0]        pa;
      int                 start;
      start = errors;
      va = {10'h0a0, 10'h155, 12'h7f8};
      pa = {10'h003, 10'h155, 12'h7f8};
      mem_write(l1_addr(va), pte_word({12'h003, 10'h000}, F_V | F_R | F_A));
      mem_write(pa, 32'h5e9e_0001);
      lsu_access(1'b0, va, '0, '0, 1'b0, resp);
      check_bus("superpage", 2, l1_addr(va), pa, '0);
      check_equal("superpage data", 32'h5e9e_0001, resp.data);
      // misaligned superpage
      va = {10'h0a1, 10'h155, 12'h7f8};
      mem_write(l1_addr(va), pte_word({12'h003, 10'h001}, F_V | F_R | F_A));
      lsu_access(1'b0, va, '0, '0, 1'b0, resp);
      check_bus("superpage misaligned", 1, l1_addr(va), '0, '0);
      expect_fault("superpage misaligned", resp, mmu_pkg::EXC_LOAD_PF, va);
      report_test("superpage", start);
   endtask

   task automatic permission_faults();
      mmu_pkg::mmu_resp_t resp;
      logic [31:0]        va [5];
      int                 start;
      start = errors;
      for (int i = 0; i < 5; i++) begin
         va[i] = {10'h0c0 + 10'(i), 10'h001, 12'h100};
      end
      map_4k(va[0], 20'h00600, F_V | F_R | F_A | F_D);
      lsu_access(1'b1, va[0], 32'hdead_beef, 4'hf, 1'b0, resp);
      expect_fault("perm store no w", resp, mmu_pkg::EXC_STORE_PF, va[0]);
      map_4k(va[1], 20'h00601, F_V | F_R | F_W | F_A);
      lsu_access(1'b1, va[1], 32'hdead_beef, 4'hf, 1'b0, resp);
      expect_fault("perm store no d", resp, mmu_pkg::EXC_STORE_PF, va[1]);
      map_4k(va[2], 20'h00602, F_V | F_R | F_A);
      fetch_access(va[2], resp);
      expect_fault("perm fetch no x", resp, mmu_pkg::EXC_INST_PF, va[2]);
      map_4k(va[3], 20'h00603, F_V | F_R | F_U | F_A);
      mem_write({20'h00603, 12'h100}, 32'h0000_5a11);
      lsu_access(1'b0, va[3], '0, '0, 1'b0, resp);
      expect_fault("perm upage sum0", resp, mmu_pkg::EXC_LOAD_PF, va[3]);
      sum <= 1'b1;
      lsu_access(1'b0, va[3], '0, '0, 1'b0, resp);
      check_equal("perm upage sum1 fault", 32'd0, 32'(resp.fault));
      check_equal("perm upage sum1 data", 32'h0000_5a11, resp.data);
      sum <= 1'b0;
      mem_write(l1_addr(va[4]), 32'h0000_0000);
      lsu_access(1'b0, va[4], '0, '0, 1'b0, resp);
      expect_fault("perm invalid pte", resp, mmu_pkg::EXC_LOAD_PF, va[4]);
      report_test("permissions", start);
   endtask

   task automatic fetch_priority();
      logic [31:0] va_f;
      logic [31:0] va_l;
      logic [31:0] fetch_data;
      logic [31:0] lsu_data;
      logic        got_fetch;
      logic        got_lsu;
      logic        fetch_first;
      int          cycles;
      int          start;
      start = errors;
      va_f = {10'h0e0, 10'h002, 12'h040};
      va_l = {10'h0e1, 10'h003, 12'h080};
      map_4k(va_f, 20'h00700, F_V | F_X | F_A);
      map_4k(va_l, 20'h00701, F_V | F_R | F_A);
      mem_write({20'h00700, 12'h040}, 32'h0000_0013);
      mem_write({20'h00701, 12'h080}, 32'h5555_aaaa);
      got_fetch   = 1'b0;
      got_lsu     = 1'b0;
      fetch_first = 1'b0;
      cycles      = 0;
      @(posedge clk);
      fetch_req <= '{valid: 1'b1, addr: va_f};
      lsu_req   <= '{valid: 1'b1, write: 1'b0, addr: va_l, wdata: '0, wstrb: '0};
      while (!(got_fetch && got_lsu) && cycles < 2 * RESP_TIMEOUT) begin
         @(posedge clk);
         cycles++;
         if (fetch_resp.valid && !got_fetch) begin
            got_fetch       = 1'b1;
            fetch_first     = !got_lsu;
            fetch_data      = fetch_resp.data;
            fetch_req.valid <= 1'b0;
         end
         if (lsu_resp.valid && !got_lsu) begin
            got_lsu       = 1'b1;
            lsu_data      = lsu_resp.data;
            lsu_req.valid <= 1'b0;
         end
      end
      assert (got_fetch && got_lsu) else begin
         $display("priority: one of the two requests never got a response");
         errors++;
      end
      assert (fetch_first) else begin
         $display("priority: load response arrived before the fetch response");
         errors++;
      end
      check_equal("priority fetch data", 32'h0000_0013, fetch_data);
      check_equal("priority load data", 32'h5555_aaaa, lsu_data);
      report_test("priority", start);
   endtask

   //////////////////////////////
   // main sequence and watchdog
   //////////////////////////////

   initial begin
      satp      = '0;
      priv      = mmu_pkg::PRIV_S;
      sum       = 1'b0;
      flush_tlb = 1'b0;
      fetch_req = '0;
      lsu_req   = '0;
      bus_resp  = '0;
      wait (rstn == 1'b0);
      @(posedge clk);
      bypass_paths();
      two_level_walk();
      tlb_hit_and_flush();
      superpage_mapping();
      permission_faults();
      fetch_priority();
      $display("summary: %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
               tests_run, tests_failed, errors, dut_i.sva_i.failures);
      if (tests_failed == 0 && errors == 0 && dut_i.sva_i.failures == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(NUM_TESTS * 2000);
      $display("watchdog: the run did not finish in time");
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: sources.f
verilog/sv32_pkg.sv
verilog/mmu_pkg.sv
verilog/mmu_tlb.sv
verilog/pte_check.sv
verilog/sv32_walker.sv
verilog/sv32_mmu.sv
test/tb_clock.sv
test/sv32_mmu_sva.sv
test/sv32_mmu_tb.sv

// File: Bender.yml
package:
  name: sv32_mmu

sources:
  - verilog/sv32_pkg.sv
  - verilog/mmu_pkg.sv
  - verilog/mmu_tlb.sv
  - verilog/pte_check.sv
  - verilog/sv32_walker.sv
  - verilog/sv32_mmu.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/sv32_mmu_sva.sv
      - test/sv32_mmu_tb.sv
